/* src/riscv_mext_defs.svh */
`ifndef RISCV_MEXT_DEFS_SVH
`define RISCV_MEXT_DEFS_SVH

// operand and result width
`define RISCV_XLEN 64

// tag width, one tag per operation in flight
`define RISCV_TAG_W 4

// one quotient bit per iteration
`define RISCV_DIV_ITER 64

`define RISCV_MUL_DEPTH 3

`endif

/* src/riscv_mext_op_pkg.sv */
`default_nettype none

`include "riscv_mext_defs.svh"

package riscv_mext_op_pkg;

	typedef enum logic [1:0]
	{
		kind_lo  = 2'b00, // mul, mulw
		kind_hsu = 2'b01, // mulhsu
		kind_hu  = 2'b10, // mulhu
		kind_hss = 2'b11  // mulh
	} mul_kind_e;

	// same bit order as the divider control word of the core
	typedef struct packed
	{
		logic start;
		logic dword; // 1 for 64-bit ops
		logic rem;
		logic unsign;
	} div_ctrl_s;

	typedef struct packed
	{
		logic      start;
		logic      dword;
		mul_kind_e kind;
	} mul_ctrl_s;

	// one control word, decoded per engine
	typedef union packed
	{
		div_ctrl_s div;
		mul_ctrl_s mul;
	} mext_ctrl_u;

endpackage

`default_nettype wire

/* src/riscv_mext_res_pkg.sv */
`default_nettype none

`include "riscv_mext_defs.svh"

package riscv_mext_res_pkg;

	// engine that owns the result bus
	typedef enum logic
	{
		src_div = 1'b0,
		src_mul = 1'b1
	} res_src_e;

	typedef logic [`RISCV_TAG_W-1:0] res_tag_t;

endpackage

`default_nettype wire

/* src/riscv_mext_issue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscv_mext_defs.svh"

module riscv_mext_issue
	import riscv_mext_op_pkg::*;
	import riscv_mext_res_pkg::*;
(
	input  wire logic                   i_riscv_div_clk,
	input  wire logic                   i_riscv_div_rst,
	input  wire logic                   i_riscv_div_req,
	input  wire logic                   i_riscv_div_is_div,
	input  wire mext_ctrl_u             i_riscv_div_ctrl,
	input  wire logic [`RISCV_XLEN-1:0] i_riscv_div_rs1data,
	input  wire logic [`RISCV_XLEN-1:0] i_riscv_div_rs2data,
	input  wire res_tag_t               i_riscv_div_tag,
	input  wire logic                   i_riscv_div_div_busy,
	input  wire logic                   i_riscv_div_mul_ready,
	output logic                        o_riscv_div_ack,
	output logic                        o_riscv_div_div_go,
	output logic                        o_riscv_div_mul_go,
	output mext_ctrl_u                  o_riscv_div_ctrl,
	output logic [`RISCV_XLEN-1:0]      o_riscv_div_op_a,
	output logic [`RISCV_XLEN-1:0]      o_riscv_div_op_b,
	output res_tag_t                    o_riscv_div_tag
);

	typedef enum logic {st_idle, st_ack} state_e;

	state_e state;
	logic   target_ok;
	logic   dispatch;

	assign target_ok = i_riscv_div_is_div ? !i_riscv_div_div_busy : i_riscv_div_mul_ready;
	assign dispatch  = (state == st_idle) && i_riscv_div_req && target_ok;

	assign o_riscv_div_div_go = dispatch && i_riscv_div_is_div;
	assign o_riscv_div_mul_go = dispatch && !i_riscv_div_is_div;
	assign o_riscv_div_ack    = dispatch || (state == st_ack); // up in the dispatch cycle

	// the core holds these stable while req is high
	assign o_riscv_div_ctrl = i_riscv_div_ctrl;
	assign o_riscv_div_op_a = i_riscv_div_rs1data;
	assign o_riscv_div_op_b = i_riscv_div_rs2data;
	assign o_riscv_div_tag  = i_riscv_div_tag;

	always_ff @(posedge i_riscv_div_clk or negedge i_riscv_div_rst)
	begin
		if (!i_riscv_div_rst)
			state <= st_idle;
		else if (state == st_idle && dispatch)
			state <= st_ack;
		else if (state == st_ack && !i_riscv_div_req)
			state <= st_idle; // ack drops next cycle
	end

endmodule

`default_nettype wire

/* src/riscv_divider.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscv_mext_defs.svh"

module riscv_divider
	import riscv_mext_op_pkg::*;
	import riscv_mext_res_pkg::*;
(
	input  wire logic                   i_riscv_div_clk,
	input  wire logic                   i_riscv_div_rst,
	input  wire logic                   i_riscv_div_go,
	input  wire mext_ctrl_u             i_riscv_div_ctrl,
	input  wire logic [`RISCV_XLEN-1:0] i_riscv_div_rs1data,
	input  wire logic [`RISCV_XLEN-1:0] i_riscv_div_rs2data,
	input  wire res_tag_t               i_riscv_div_tag,
	input  wire logic                   i_riscv_div_grant,
	output logic                        o_riscv_div_busy,
	output logic                        o_riscv_div_done,
	output logic [`RISCV_XLEN-1:0]      o_riscv_div_result,
	output res_tag_t                    o_riscv_div_tag
);

	localparam int unsigned xl    = `RISCV_XLEN;
	localparam int unsigned half  = `RISCV_XLEN / 2;
	localparam int unsigned cnt_w = $clog2(`RISCV_DIV_ITER);
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`RISCV_DIV_ITER - 1);

	typedef enum logic [1:0] {st_idle, st_run, st_done} state_e;

	state_e            state;
	logic [cnt_w-1:0]  count;
	div_ctrl_s         ctrl;
	logic [xl-1:0]     ext_a;
	logic [xl-1:0]     ext_b;
	logic [xl-1:0]     min_val;
	logic              neg_a_in;
	logic              neg_b_in;
	logic [2*xl-1:0]   z;      // remainder high, quotient low
	logic [2*xl-1:0]   z_nxt;
	logic [xl:0]       hi;
	logic [xl:0]       diff;
	logic [xl-1:0]     y;
	logic [xl-1:0]     a_raw;
	logic              dword_q;
	logic              rem_q;
	logic              neg_a_q;
	logic              neg_b_q;
	logic              zero_q;
	logic              ovf_q;
	logic [xl-1:0]     q_fix;
	logic [xl-1:0]     r_fix;
	logic [xl-1:0]     sel;

	// word ops look at the low half only
	function automatic logic [xl-1:0] ext_op(input logic [xl-1:0] v, input div_ctrl_s c);
		if (c.dword)
			return v;
		else if (c.unsign)
			return {{half{1'b0}}, v[half-1:0]};
		else
			return {{half{v[half-1]}}, v[half-1:0]};
	endfunction

	assign ctrl     = i_riscv_div_ctrl.div;
	assign ext_a    = ext_op(i_riscv_div_rs1data, ctrl);
	assign ext_b    = ext_op(i_riscv_div_rs2data, ctrl);
	assign neg_a_in = !ctrl.unsign && ext_a[xl-1];
	assign neg_b_in = !ctrl.unsign && ext_b[xl-1];
	assign min_val  = ctrl.dword ? {1'b1, {(xl-1){1'b0}}} : {{(half+1){1'b1}}, {(half-1){1'b0}}};

	// one restoring step, 65-bit compare so large unsigned divisors work
	assign hi    = z[2*xl-1:xl-1];
	assign diff  = hi - {1'b0, y};
	assign z_nxt = diff[xl] ? {hi[xl-1:0], z[xl-2:0], 1'b0} : {diff[xl-1:0], z[xl-2:0], 1'b1};

	always_ff @(posedge i_riscv_div_clk or negedge i_riscv_div_rst)
	begin
		if (!i_riscv_div_rst)
		begin
			state <= st_idle;
			count <= '0;
		end
		else
		begin
			case (state)
				st_idle:
					if (i_riscv_div_go)
					begin
						state <= st_run;
						count <= '0;
					end
				st_run:
				begin
					count <= count + 1'b1;
					if (count == cnt_last)
						state <= st_done; // done with the last quotient bit
				end
				st_done:
					if (i_riscv_div_grant)
						state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge i_riscv_div_clk)
	begin
		if (state == st_idle && i_riscv_div_go)
		begin
			z              <= {{xl{1'b0}}, neg_a_in ? -ext_a : ext_a};
			y              <= neg_b_in ? -ext_b : ext_b;
			a_raw          <= ext_a;
			dword_q        <= ctrl.dword;
			rem_q          <= ctrl.rem;
			neg_a_q        <= neg_a_in;
			neg_b_q        <= neg_b_in;
			zero_q         <= (ext_b == '0);
			ovf_q          <= !ctrl.unsign && (ext_a == min_val) && (&ext_b);
			o_riscv_div_tag <= i_riscv_div_tag;
		end
		else if (state == st_run)
		begin
			z <= z_nxt;
		end
	end

	assign q_fix = (neg_a_q ^ neg_b_q) ? -z[xl-1:0] : z[xl-1:0];
	assign r_fix = neg_a_q ? -z[2*xl-1:xl] : z[2*xl-1:xl]; // sign of the dividend

	always_comb
	begin
		if (zero_q)
			sel = rem_q ? a_raw : '1;
		else if (ovf_q)
			sel = rem_q ? '0 : a_raw;
		else
			sel = rem_q ? r_fix : q_fix;
	end

	assign o_riscv_div_result = dword_q ? sel : {{half{sel[half-1]}}, sel[half-1:0]};
	assign o_riscv_div_busy   = (state != st_idle);
	assign o_riscv_div_done   = (state == st_done);

endmodule

`default_nettype wire

/* src/riscv_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscv_mext_defs.svh"

module riscv_multiplier
	import riscv_mext_op_pkg::*;
	import riscv_mext_res_pkg::*;
(
	input  wire logic                   i_riscv_div_clk,
	input  wire logic                   i_riscv_div_rst,
	input  wire logic                   i_riscv_div_go,
	input  wire mext_ctrl_u             i_riscv_div_ctrl,
	input  wire logic [`RISCV_XLEN-1:0] i_riscv_div_rs1data,
	input  wire logic [`RISCV_XLEN-1:0] i_riscv_div_rs2data,
	input  wire res_tag_t               i_riscv_div_tag,
	input  wire logic                   i_riscv_div_grant,
	output logic                        o_riscv_div_ready,
	output logic                        o_riscv_div_done,
	output logic [`RISCV_XLEN-1:0]      o_riscv_div_result,
	output res_tag_t                    o_riscv_div_tag
);

	localparam int unsigned xl    = `RISCV_XLEN;
	localparam int unsigned half  = `RISCV_XLEN / 2;
	localparam int unsigned depth = `RISCV_MUL_DEPTH;

	mul_ctrl_s             ctrl;
	logic                  sgn_a;
	logic                  sgn_b;
	logic                  stall;
	logic [depth-1:0]      vld;
	res_tag_t              tag_q [depth];
	logic [xl-1:0]         s1_a;   // magnitudes
	logic [xl-1:0]         s1_b;
	logic                  s1_neg;
	logic                  s1_dword;
	logic                  s1_high;
	logic [xl-1:0]         s2_ll;
	logic [xl-1:0]         s2_lh;
	logic [xl-1:0]         s2_hl;
	logic [xl-1:0]         s2_hh;
	logic                  s2_neg;
	logic                  s2_dword;
	logic                  s2_high;
	logic [2*xl-1:0]       sum;
	logic [2*xl-1:0]       prod;
	logic [xl-1:0]         s3_res;

	assign ctrl  = i_riscv_div_ctrl.mul;
	assign sgn_a = (ctrl.kind == kind_hss) || (ctrl.kind == kind_hsu);
	assign sgn_b = (ctrl.kind == kind_hss);

	// the whole pipe holds while a finished result waits for the bus
	assign stall             = vld[depth-1] && !i_riscv_div_grant;
	assign o_riscv_div_ready = !stall;

	always_ff @(posedge i_riscv_div_clk or negedge i_riscv_div_rst)
	begin
		if (!i_riscv_div_rst)
			vld <= '0;
		else if (!stall)
			vld <= {vld[depth-2:0], i_riscv_div_go};
	end

	assign sum  = {s2_hh, s2_ll} + {{half{1'b0}}, s2_lh, {half{1'b0}}}
		+ {{half{1'b0}}, s2_hl, {half{1'b0}}};
	assign prod = s2_neg ? -sum : sum;

	always_ff @(posedge i_riscv_div_clk)
	begin
		if (!stall)
		begin
			tag_q[0] <= i_riscv_div_tag;
			for (int i = 1; i < depth; i++)
				tag_q[i] <= tag_q[i-1];
			// stage 1, sign handling by kind
			s1_a     <= (sgn_a && i_riscv_div_rs1data[xl-1]) ? -i_riscv_div_rs1data
				: i_riscv_div_rs1data;
			s1_b     <= (sgn_b && i_riscv_div_rs2data[xl-1]) ? -i_riscv_div_rs2data
				: i_riscv_div_rs2data;
			s1_neg   <= (sgn_a && i_riscv_div_rs1data[xl-1]) ^ (sgn_b && i_riscv_div_rs2data[xl-1]);
			s1_dword <= ctrl.dword;
			s1_high  <= (ctrl.kind != kind_lo);
			// stage 2, partial products
			s2_ll    <= s1_a[half-1:0] * s1_b[half-1:0];
			s2_lh    <= s1_a[half-1:0] * s1_b[xl-1:half];
			s2_hl    <= s1_a[xl-1:half] * s1_b[half-1:0];
			s2_hh    <= s1_a[xl-1:half] * s1_b[xl-1:half];
			s2_neg   <= s1_neg;
			s2_dword <= s1_dword;
			s2_high  <= s1_high;
			// stage 3, sum and pick
			if (s2_high)
				s3_res <= prod[2*xl-1:xl];
			else if (s2_dword)
				s3_res <= prod[xl-1:0];
			else
				s3_res <= {{half{prod[half-1]}}, prod[half-1:0]}; // mulw
		end
	end

	assign o_riscv_div_done   = vld[depth-1];
	assign o_riscv_div_result = s3_res;
	assign o_riscv_div_tag    = tag_q[depth-1];

endmodule

`default_nettype wire

/* src/riscv_result_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscv_mext_defs.svh"

module riscv_result_arbiter
	import riscv_mext_res_pkg::*;
(
	input  wire logic                   i_riscv_div_clk,
	input  wire logic                   i_riscv_div_rst,
	input  wire logic                   i_riscv_div_div_done,
	input  wire logic [`RISCV_XLEN-1:0] i_riscv_div_div_result,
	input  wire res_tag_t               i_riscv_div_div_tag,
	input  wire logic                   i_riscv_div_mul_done,
	input  wire logic [`RISCV_XLEN-1:0] i_riscv_div_mul_result,
	input  wire res_tag_t               i_riscv_div_mul_tag,
	output logic                        o_riscv_div_div_grant,
	output logic                        o_riscv_div_mul_grant,
	output logic                        o_riscv_div_res_valid,
	output res_src_e                    o_riscv_div_res_src,
	output res_tag_t                    o_riscv_div_res_tag,
	output logic [`RISCV_XLEN-1:0]      o_riscv_div_result
);

	// divider wins, it has waited far longer
	assign o_riscv_div_div_grant = i_riscv_div_div_done;
	assign o_riscv_div_mul_grant = i_riscv_div_mul_done && !i_riscv_div_div_done;

	always_ff @(posedge i_riscv_div_clk or negedge i_riscv_div_rst)
	begin
		if (!i_riscv_div_rst)
			o_riscv_div_res_valid <= 1'b0;
		else
			o_riscv_div_res_valid <= i_riscv_div_div_done || i_riscv_div_mul_done;
	end

	always_ff @(posedge i_riscv_div_clk)
	begin
		if (o_riscv_div_div_grant)
		begin
			o_riscv_div_res_src <= src_div;
			o_riscv_div_res_tag <= i_riscv_div_div_tag;
			o_riscv_div_result  <= i_riscv_div_div_result;
		end
		else if (o_riscv_div_mul_grant)
		begin
			o_riscv_div_res_src <= src_mul;
			o_riscv_div_res_tag <= i_riscv_div_mul_tag;
			o_riscv_div_result  <= i_riscv_div_mul_result;
		end
	end

endmodule

`default_nettype wire

/* src/riscv_mext_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscv_mext_defs.svh"

module riscv_mext_top
	import riscv_mext_op_pkg::*;
	import riscv_mext_res_pkg::*;
(
	input  wire logic                   i_riscv_div_clk,
	input  wire logic                   i_riscv_div_rst,
	input  wire logic                   i_riscv_div_req,
	input  wire logic                   i_riscv_div_is_div,
	input  wire mext_ctrl_u             i_riscv_div_ctrl,
	input  wire logic [`RISCV_XLEN-1:0] i_riscv_div_rs1data,
	input  wire logic [`RISCV_XLEN-1:0] i_riscv_div_rs2data,
	input  wire res_tag_t               i_riscv_div_tag,
	output logic                        o_riscv_div_ack,
	output logic                        o_riscv_div_res_valid,
	output res_src_e                    o_riscv_div_res_src,
	output res_tag_t                    o_riscv_div_res_tag,
	output logic [`RISCV_XLEN-1:0]      o_riscv_div_result
);

	logic                   div_busy;
	logic                   mul_ready;
	logic                   div_go;
	logic                   mul_go;
	mext_ctrl_u             eng_ctrl;
	logic [`RISCV_XLEN-1:0] op_a;
	logic [`RISCV_XLEN-1:0] op_b;
	res_tag_t               eng_tag;
	logic                   div_grant;
	logic                   mul_grant;
	logic                   div_done;
	logic                   mul_done;
	logic [`RISCV_XLEN-1:0] div_result;
	logic [`RISCV_XLEN-1:0] mul_result;
	res_tag_t               div_tag;
	res_tag_t               mul_tag;

	riscv_mext_issue u_issue (
		.i_riscv_div_clk       (i_riscv_div_clk),
		.i_riscv_div_rst       (i_riscv_div_rst),
		.i_riscv_div_req       (i_riscv_div_req),
		.i_riscv_div_is_div    (i_riscv_div_is_div),
		.i_riscv_div_ctrl      (i_riscv_div_ctrl),
		.i_riscv_div_rs1data   (i_riscv_div_rs1data),
		.i_riscv_div_rs2data   (i_riscv_div_rs2data),
		.i_riscv_div_tag       (i_riscv_div_tag),
		.i_riscv_div_div_busy  (div_busy),
		.i_riscv_div_mul_ready (mul_ready),
		.o_riscv_div_ack       (o_riscv_div_ack),
		.o_riscv_div_div_go    (div_go),
		.o_riscv_div_mul_go    (mul_go),
		.o_riscv_div_ctrl      (eng_ctrl),
		.o_riscv_div_op_a      (op_a),
		.o_riscv_div_op_b      (op_b),
		.o_riscv_div_tag       (eng_tag)
	);

	riscv_divider u_div (
		.i_riscv_div_clk     (i_riscv_div_clk),
		.i_riscv_div_rst     (i_riscv_div_rst),
		.i_riscv_div_go      (div_go),
		.i_riscv_div_ctrl    (eng_ctrl),
		.i_riscv_div_rs1data (op_a),
		.i_riscv_div_rs2data (op_b),
		.i_riscv_div_tag     (eng_tag),
		.i_riscv_div_grant   (div_grant),
		.o_riscv_div_busy    (div_busy),
		.o_riscv_div_done    (div_done),
		.o_riscv_div_result  (div_result),
		.o_riscv_div_tag     (div_tag)
	);

	riscv_multiplier u_mul (
		.i_riscv_div_clk     (i_riscv_div_clk),
		.i_riscv_div_rst     (i_riscv_div_rst),
		.i_riscv_div_go      (mul_go),
		.i_riscv_div_ctrl    (eng_ctrl),
		.i_riscv_div_rs1data (op_a),
		.i_riscv_div_rs2data (op_b),
		.i_riscv_div_tag     (eng_tag),
		.i_riscv_div_grant   (mul_grant),
		.o_riscv_div_ready   (mul_ready),
		.o_riscv_div_done    (mul_done),
		.o_riscv_div_result  (mul_result),
		.o_riscv_div_tag     (mul_tag)
	);

	riscv_result_arbiter u_arb (
		.i_riscv_div_clk        (i_riscv_div_clk),
		.i_riscv_div_rst        (i_riscv_div_rst),
		.i_riscv_div_div_done   (div_done),
		.i_riscv_div_div_result (div_result),
		.i_riscv_div_div_tag    (div_tag),
		.i_riscv_div_mul_done   (mul_done),
		.i_riscv_div_mul_result (mul_result),
		.i_riscv_div_mul_tag    (mul_tag),
		.o_riscv_div_div_grant  (div_grant),
		.o_riscv_div_mul_grant  (mul_grant),
		.o_riscv_div_res_valid  (o_riscv_div_res_valid),
		.o_riscv_div_res_src    (o_riscv_div_res_src),
		.o_riscv_div_res_tag    (o_riscv_div_res_tag),
		.o_riscv_div_result     (o_riscv_div_result)
	);

endmodule

`default_nettype wire

/* dv/riscv_mext_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_mext_clkgen
(
	output logic o_riscv_div_clk,
	output logic o_riscv_div_rst
);

	// 100 ns period
	initial
	begin
		o_riscv_div_clk = 1'b0;
		forever
			#50 o_riscv_div_clk = ~o_riscv_div_clk;
	end

	// active low for the first 10 cycles
	initial
	begin
		o_riscv_div_rst = 1'b0;
		repeat (10)
			@(posedge o_riscv_div_clk);
		#10 o_riscv_div_rst = 1'b1;
	end

endmodule

`default_nettype wire

/* dv/riscv_mext_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_mext_sva
	import riscv_mext_res_pkg::*;
(
	input wire logic     i_riscv_div_clk,
	input wire logic     i_riscv_div_rst,
	input wire logic     i_riscv_div_req,
	input wire logic     i_riscv_div_ack,
	input wire logic     i_riscv_div_res_valid,
	input wire res_tag_t i_riscv_div_res_tag,
	input wire logic     i_riscv_div_div_grant,
	input wire logic     i_riscv_div_mul_grant
);

	int unsigned fail_count = 0; // read by the testbench

	ack_needs_req: assert property (@(posedge i_riscv_div_clk) disable iff (!i_riscv_div_rst)
		$rose(i_riscv_div_ack) |-> i_riscv_div_req)
	else
	begin
		$error("ack rose without req");
		fail_count++;
	end

	// four-phase, req stays up until acked
	req_holds: assert property (@(posedge i_riscv_div_clk) disable iff (!i_riscv_div_rst)
		i_riscv_div_req && !i_riscv_div_ack |=> i_riscv_div_req)
	else
	begin
		$error("req dropped before ack");
		fail_count++;
	end

	tag_known: assert property (@(posedge i_riscv_div_clk) disable iff (!i_riscv_div_rst)
		i_riscv_div_res_valid |-> !$isunknown(i_riscv_div_res_tag))
	else
	begin
		$error("result bus valid with an unknown tag");
		fail_count++;
	end

	one_grant: assert property (@(posedge i_riscv_div_clk) disable iff (!i_riscv_div_rst)
		!(i_riscv_div_div_grant && i_riscv_div_mul_grant))
	else
	begin
		$error("both engines granted together");
		fail_count++;
	end

endmodule

`default_nettype wire

/* dv/riscv_mext_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscv_mext_defs.svh"

module riscv_mext_tb
	import riscv_mext_op_pkg::*;
	import riscv_mext_res_pkg::*;
;

	localparam int xl        = `RISCV_XLEN;
	localparam int n_tags    = 1 << `RISCV_TAG_W;
	localparam int n_fixed   = 21;
	localparam int n_entries = 24;
	localparam int timeout_cycles = n_entries * 70 + 100;

	// bit 4 selects the divider and bits 3:0 are the control word
	localparam logic [4:0] op_div    = 5'h1C;
	localparam logic [4:0] op_divu   = 5'h1D;
	localparam logic [4:0] op_rem    = 5'h1E;
	localparam logic [4:0] op_remu   = 5'h1F;
	localparam logic [4:0] op_divw   = 5'h18;
	localparam logic [4:0] op_divuw  = 5'h19;
	localparam logic [4:0] op_remw   = 5'h1A;
	localparam logic [4:0] op_remuw  = 5'h1B;
	localparam logic [4:0] op_mul    = 5'h0C;
	localparam logic [4:0] op_mulh   = 5'h0F;
	localparam logic [4:0] op_mulhsu = 5'h0D;
	localparam logic [4:0] op_mulhu  = 5'h0E;
	localparam logic [4:0] op_mulw   = 5'h08;
	localparam logic [4:0] rand_ops [13] = '{op_div, op_divu, op_rem, op_remu, op_divw,
		op_divuw, op_remw, op_remuw, op_mul, op_mulh, op_mulhsu, op_mulhu, op_mulw};

	logic          clk;
	logic          rst;
	logic          req;
	logic          is_div;
	mext_ctrl_u    ctrl;
	logic [xl-1:0] rs1;
	logic [xl-1:0] rs2;
	res_tag_t      tag;
	logic          ack;
	logic          res_valid;
	res_src_e      res_src;
	res_tag_t      res_tag;
	logic [xl-1:0] result;

	logic [4:0]    op_tab [n_entries];
	logic [xl-1:0] a_tab [n_entries];
	logic [xl-1:0] b_tab [n_entries];
	logic [xl-1:0] exp_tab [n_entries];

	// scoreboard indexed by tag
	logic          pending [n_tags];
	logic          behind_div [n_tags]; // mul issued while a division ran
	logic [xl-1:0] exp_res [n_tags];
	res_src_e      exp_src [n_tags];
	res_tag_t      div_q [$];
	res_tag_t      mul_q [$];
	int            pending_count;
	int            div_count;
	int            cycle_count;
	integer        seed;
	res_tag_t      got_tag;

	riscv_mext_clkgen u_clkgen (
		.o_riscv_div_clk (clk),
		.o_riscv_div_rst (rst)
	);

	riscv_mext_top dut (
		.i_riscv_div_clk       (clk),
		.i_riscv_div_rst       (rst),
		.i_riscv_div_req       (req),
		.i_riscv_div_is_div    (is_div),
		.i_riscv_div_ctrl      (ctrl),
		.i_riscv_div_rs1data   (rs1),
		.i_riscv_div_rs2data   (rs2),
		.i_riscv_div_tag       (tag),
		.o_riscv_div_ack       (ack),
		.o_riscv_div_res_valid (res_valid),
		.o_riscv_div_res_src   (res_src),
		.o_riscv_div_res_tag   (res_tag),
		.o_riscv_div_result    (result)
	);

	bind riscv_mext_top riscv_mext_sva u_sva (
		.i_riscv_div_clk       (i_riscv_div_clk),
		.i_riscv_div_rst       (i_riscv_div_rst),
		.i_riscv_div_req       (i_riscv_div_req),
		.i_riscv_div_ack       (o_riscv_div_ack),
		.i_riscv_div_res_valid (o_riscv_div_res_valid),
		.i_riscv_div_res_tag   (o_riscv_div_res_tag),
		.i_riscv_div_div_grant (div_grant),
		.i_riscv_div_mul_grant (mul_grant)
	);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_result(input string name, input logic [xl-1:0] got,
		input logic [xl-1:0] exp);
		if (got !== exp)
			report_failure($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_tag(input string name, input res_tag_t got, input res_tag_t exp);
		if (got !== exp)
			report_failure($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_src(input string name, input res_src_e got, input res_src_e exp);
		if (got !== exp)
			report_failure($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	function automatic logic [xl-1:0] sext_word(input logic [31:0] w);
		return {{32{w[31]}}, w};
	endfunction

	// RISC-V division rules with sign-extended word results
	function automatic logic [xl-1:0] ref_divide(input logic [3:0] code,
		input logic [xl-1:0] a, input logic [xl-1:0] b);
		logic          dword;
		logic          rem;
		logic          uns;
		logic [xl-1:0] x;
		logic [xl-1:0] y;
		logic [xl-1:0] min_neg;
		logic [xl-1:0] r;
		dword   = code[2];
		rem     = code[1];
		uns     = code[0];
		x       = dword ? a : (uns ? {32'h0, a[31:0]} : sext_word(a[31:0]));
		y       = dword ? b : (uns ? {32'h0, b[31:0]} : sext_word(b[31:0]));
		min_neg = dword ? 64'h8000_0000_0000_0000 : 64'hFFFF_FFFF_8000_0000;
		if (y == '0)
			r = rem ? x : '1;
		else if (!uns && x == min_neg && y == '1)
			r = rem ? '0 : x;
		else if (uns)
			r = rem ? x % y : x / y;
		else if (rem)
			r = $signed(x) % $signed(y); // takes the sign of the dividend
		else
			r = $signed(x) / $signed(y);
		return dword ? r : sext_word(r[31:0]);
	endfunction

	function automatic logic [xl-1:0] ref_multiply(input logic [3:0] code,
		input logic [xl-1:0] a, input logic [xl-1:0] b);
		mul_kind_e       kind;
		logic [2*xl-1:0] ea;
		logic [2*xl-1:0] eb;
		logic [2*xl-1:0] p;
		kind = mul_kind_e'(code[1:0]);
		ea   = (kind == kind_hss || kind == kind_hsu) ? {{xl{a[xl-1]}}, a} : {{xl{1'b0}}, a};
		eb   = (kind == kind_hss) ? {{xl{b[xl-1]}}, b} : {{xl{1'b0}}, b};
		p    = ea * eb;
		if (kind != kind_lo)
			return p[2*xl-1:xl];
		else if (code[2])
			return p[xl-1:0];
		else
			return sext_word(p[31:0]); // mulw
	endfunction

	task automatic set_entry(input int idx, input logic [4:0] op, input logic [xl-1:0] a,
		input logic [xl-1:0] b, input logic [xl-1:0] exp);
		op_tab[idx]  = op;
		a_tab[idx]   = a;
		b_tab[idx]   = b;
		exp_tab[idx] = exp;
	endtask

	// four-phase request on a tag whose last result has returned
	task automatic issue_entry(input int idx);
		res_tag_t t;
		t = res_tag_t'(idx % n_tags);
		while (pending[t])
			@(negedge clk);
		@(posedge clk);
		#10;
		exp_res[t]    = exp_tab[idx];
		exp_src[t]    = op_tab[idx][4] ? src_div : src_mul;
		behind_div[t] = !op_tab[idx][4] && (div_count != 0);
		pending[t]    = 1'b1;
		pending_count++;
		if (op_tab[idx][4])
		begin
			div_count++;
			div_q.push_back(t);
		end
		else
			mul_q.push_back(t);
		req    = 1'b1;
		is_div = op_tab[idx][4];
		ctrl   = op_tab[idx][3:0];
		rs1    = a_tab[idx];
		rs2    = b_tab[idx];
		tag    = t;
		do
			@(negedge clk);
		while (!ack);
		@(posedge clk);
		#10;
		req = 1'b0;
		do
			@(negedge clk);
		while (ack);
	endtask

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= timeout_cycles)
			report_failure($sformatf("timeout, run not finished after %0d cycles", cycle_count));
	end

	// registered bus outputs are stable at the falling edge
	always @(negedge clk)
	begin
		if (dut.u_sva.fail_count != 0)
			report_failure("an assertion on the DUT failed");
		if (rst && res_valid)
		begin
			got_tag = res_tag;
			if (!pending[got_tag])
				report_failure($sformatf("result with tag %0d had no operation pending", got_tag));
			check_src("o_riscv_div_res_src", res_src, exp_src[got_tag]);
			check_result("o_riscv_div_result", result, exp_res[got_tag]);
			if (res_src == src_div)
			begin
				check_tag("o_riscv_div_res_tag", got_tag, div_q.pop_front());
				for (int k = 0; k < n_tags; k++)
					if (pending[k] && behind_div[k])
						report_failure("a multiply issued during a division finished after it");
				div_count--;
			end
			else
				check_tag("o_riscv_div_res_tag", got_tag, mul_q.pop_front()); // in order
			pending[got_tag] = 1'b0;
			pending_count--;
		end
	end

	initial
	begin
		logic [4:0]    op;
		logic [xl-1:0] a;
		logic [xl-1:0] b;
		req           = 1'b0;
		is_div        = 1'b0;
		ctrl          = '0;
		rs1           = '0;
		rs2           = '0;
		tag           = '0;
		seed          = 32'h308b;
		pending_count = 0;
		div_count     = 0;
		cycle_count   = 0;
		for (int k = 0; k < n_tags; k++)
		begin
			pending[k]    = 1'b0;
			behind_div[k] = 1'b0;
		end
		set_entry(0, op_div, -64'sd20, 64'd6, 64'hFFFF_FFFF_FFFF_FFFD);
		set_entry(1, op_mul, 64'h1234_5678, 64'h10, 64'h0000_0001_2345_6780);
		set_entry(2, op_mulh, 64'h8000_0000_0000_0000, 64'd2, 64'hFFFF_FFFF_FFFF_FFFF);
		set_entry(3, op_mulhu, '1, '1, 64'hFFFF_FFFF_FFFF_FFFE);
		set_entry(4, op_rem, -64'sd20, 64'd6, 64'hFFFF_FFFF_FFFF_FFFE);
		set_entry(5, op_mulhsu, '1, '1, 64'hFFFF_FFFF_FFFF_FFFF);
		set_entry(6, op_divu, 64'd100, 64'd7, 64'd14);
		set_entry(7, op_mulw, 64'hABCD_0000_7FFF_FFFF, 64'd2, 64'hFFFF_FFFF_FFFF_FFFE);
		set_entry(8, op_remu, 64'd100, 64'd7, 64'd2);
		set_entry(9, op_divw, 64'h0000_0000_FFFF_FFF0, 64'h1234_5678_0000_0003,
			64'hFFFF_FFFF_FFFF_FFFB);
		set_entry(10, op_remw, 64'h0000_0000_FFFF_FFF0, 64'h1234_5678_0000_0003, '1);
		set_entry(11, op_divuw, 64'hFFFF_FFFF_FFFF_FFF0, 64'h10, 64'h0000_0000_0FFF_FFFF);
		set_entry(12, op_remuw, 64'h8000_0005, 64'h9000_0000, 64'hFFFF_FFFF_8000_0005);
		set_entry(13, op_div, 64'h1234, 64'd0, '1); // divide by zero
		set_entry(14, op_rem, 64'h1234, 64'd0, 64'h1234);
		set_entry(15, op_divuw, 64'h55, 64'hFFFF_FFFF_0000_0000, '1);
		set_entry(16, op_remw, 64'h8000_0000, 64'd0, 64'hFFFF_FFFF_8000_0000);
		set_entry(17, op_div, 64'h8000_0000_0000_0000, '1, 64'h8000_0000_0000_0000);
		set_entry(18, op_rem, 64'h8000_0000_0000_0000, '1, 64'd0);
		set_entry(19, op_divw, 64'h8000_0000, 64'hFFFF_FFFF, 64'hFFFF_FFFF_8000_0000);
		set_entry(20, op_mul, -64'sd3, 64'd5, 64'hFFFF_FFFF_FFFF_FFF1);
		for (int i = n_fixed; i < n_entries; i++)
		begin
			op = rand_ops[$unsigned($random(seed)) % 13];
			a  = {$random(seed), $random(seed)};
			b  = {$random(seed), $random(seed)};
			set_entry(i, op, a, b, op[4] ? ref_divide(op[3:0], a, b) : ref_multiply(op[3:0], a, b));
		end
		wait (rst === 1'b1);
		for (int i = 0; i < n_entries; i++)
			issue_entry(i);
		while (pending_count != 0)
			@(negedge clk);
		repeat (2)
			@(negedge clk);
		if (dut.u_sva.fail_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+src
src/riscv_mext_op_pkg.sv
src/riscv_mext_res_pkg.sv
src/riscv_mext_issue.sv
src/riscv_divider.sv
src/riscv_multiplier.sv
src/riscv_result_arbiter.sv
src/riscv_mext_top.sv
dv/riscv_mext_clkgen.sv
dv/riscv_mext_sva.sv
dv/riscv_mext_tb.sv
